// ==== trace_pkg.sv ====
/*
  Shared definitions for the trace pattern matcher:
  window, rule and event widths, rule count, initial event credits,
  the vector typedefs and the config field encoding.
*/
`default_nettype none

package trace_pkg;

   localparam int NUM_RULES      = 8;                    // pattern match rules
   localparam int WINDOW_NIBBLES = 16;                   // nibbles per window
   localparam int WINDOW_BITS    = 4 * WINDOW_NIBBLES;   // 64 bit window
   localparam int STAMP_BITS     = 16;                   // timestamp width
   localparam int EVT_CREDITS    = 4;                    // credits after reset

   typedef logic [3:0]             nibble_t;       // one trace nibble
   typedef logic [WINDOW_BITS-1:0] window_t;       // trace window
   typedef logic [STAMP_BITS-1:0]  stamp_t;        // trace_clk cycles
   typedef logic [2:0]             rule_idx_t;     // rule number
   typedef logic [NUM_RULES-1:0]   rule_vec_t;     // one bit per rule
   typedef logic [2:0]             credit_t;       // holds 0..EVT_CREDITS
   typedef logic [7:0]             drop_count_t;   // saturating drop count

   // which rule register a config write targets
   typedef enum logic [1:0] {
      cfg_pattern = 2'd0,   // full pattern word
      cfg_mask    = 2'd1,   // full mask word
      cfg_enable  = 2'd2    // bit 0 rule enable, bit 1 trigger enable
   } cfg_field_e;

endpackage

`default_nettype wire

// ==== trace_bus_if.sv ====
/*
  Bus from the trace shifter to the match rules and the reporter.
  Carries the window with its timestamp and the registered config write.
*/
`timescale 1ns/100ps
`default_nettype none

interface trace_bus_if (
   input logic trace_clk,
   input logic reset
);
   import trace_pkg::*;

   window_t    window;         // newest nibble in bits 3:0
   stamp_t     stamp;          // stamp of newest nibble
   logic       window_valid;   // window holds 16 fresh nibbles
   logic       cfg_wr;
   rule_idx_t  cfg_rule;
   cfg_field_e cfg_field;
   window_t    cfg_data;

   modport src (
      output window, stamp, window_valid,
      output cfg_wr, cfg_rule, cfg_field, cfg_data
   );

   modport rule (
      input trace_clk, reset,
      input window, stamp, window_valid,
      input cfg_wr, cfg_rule, cfg_field, cfg_data
   );

   modport mon (
      input trace_clk, reset,
      input window, stamp, window_valid
   );

endinterface

`default_nettype wire

// ==== trace_shifter.sv ====
/*
  Trace front end with nibble shift register, fill counter and window valid,
  free running timestamp counter and config write register stage.
*/
`timescale 1ns/100ps
`default_nettype none

module trace_shifter (
   input  logic                   trace_clk,
   input  logic                   reset,
   input  logic                   trace_en,
   input  trace_pkg::nibble_t     trace_data,
   input  logic                   cfg_wr,
   input  trace_pkg::rule_idx_t   cfg_rule,
   input  trace_pkg::cfg_field_e  cfg_field,
   input  trace_pkg::window_t     cfg_data,
   trace_bus_if.src               bus
);
   import trace_pkg::*;

   localparam int FILL_BITS = $clog2(WINDOW_NIBBLES);

   logic [FILL_BITS-1:0] fill_cnt;    // nibbles sampled up to 15
   stamp_t               stamp_cnt;   // edges since reset release

   // shift in the newest nibble with its stamp
   always_ff @(posedge trace_clk) begin
      if (trace_en) begin
         bus.window <= {bus.window[WINDOW_BITS-5:0], trace_data};
         bus.stamp  <= stamp_cnt;     // value at the sampling edge
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         fill_cnt         <= '0;
         bus.window_valid <= 1'b0;
      end else if (!trace_en) begin
         fill_cnt         <= '0;      // gap in the stream restarts fill
         bus.window_valid <= 1'b0;
      end else begin
         if (fill_cnt != FILL_BITS'(WINDOW_NIBBLES - 1))
            fill_cnt <= fill_cnt + 1'b1;
         // this edge samples the 16th nibble or later
         bus.window_valid <= (fill_cnt == FILL_BITS'(WINDOW_NIBBLES - 1));
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset)
         stamp_cnt <= '0;             // reads 0 at first edge after reset
      else
         stamp_cnt <= stamp_cnt + 1'b1;
   end

   // config write register stage
   always_ff @(posedge trace_clk) begin
      if (reset)
         bus.cfg_wr <= 1'b0;
      else
         bus.cfg_wr <= cfg_wr;
   end

   always_ff @(posedge trace_clk) begin
      bus.cfg_rule  <= cfg_rule;
      bus.cfg_field <= cfg_field;
      bus.cfg_data  <= cfg_data;
   end

endmodule

`default_nettype wire

// ==== pattern_rule.sv ====
/*
  Single pattern match rule with config registers for pattern, mask and
  enables, masked window compare and registered hit outputs.
*/
`timescale 1ns/100ps
`default_nettype none

module pattern_rule #(
   parameter trace_pkg::rule_idx_t RULE_ID = '0
) (
   trace_bus_if.rule bus,
   output logic      hit,
   output logic      trig_hit
);
   import trace_pkg::*;

   window_t pattern;
   window_t mask;          // 1 = bit must match
   logic    rule_en;
   logic    trig_en;
   logic    cfg_sel;       // write addressed to this rule
   logic    match;

   assign cfg_sel = bus.cfg_wr && (bus.cfg_rule == RULE_ID);

   // pattern and mask words
   always_ff @(posedge bus.trace_clk) begin
      if (cfg_sel && bus.cfg_field == cfg_pattern)
         pattern <= bus.cfg_data;
      if (cfg_sel && bus.cfg_field == cfg_mask)
         mask <= bus.cfg_data;
   end

   always_ff @(posedge bus.trace_clk) begin
      if (bus.reset) begin
         rule_en <= 1'b0;
         trig_en <= 1'b0;
      end else if (cfg_sel && bus.cfg_field == cfg_enable) begin
         rule_en <= bus.cfg_data[0];
         trig_en <= bus.cfg_data[1];
      end
   end

   assign match = bus.window_valid && rule_en
                  && (((bus.window ^ pattern) & mask) == '0);

   always_ff @(posedge bus.trace_clk) begin
      if (bus.reset) begin
         hit      <= 1'b0;
         trig_hit <= 1'b0;
      end else begin
         hit      <= match;
         trig_hit <= match && trig_en;   // same edge as hit
      end
   end

endmodule

`default_nettype wire

// ==== match_reporter.sv ====
/*
  Match reporter: window and stamp alignment, lowest rule priority pick,
  trigger pulse, credit counter, event issue and saturating drop count.
*/
`timescale 1ns/100ps
`default_nettype none

module match_reporter (
   trace_bus_if.mon                   bus,
   input  trace_pkg::rule_vec_t       hits,
   input  trace_pkg::rule_vec_t       trig_hits,
   input  logic                       evt_credit,
   output logic                       evt_valid,
   output trace_pkg::rule_idx_t       evt_rule,
   output trace_pkg::window_t         evt_window,
   output trace_pkg::stamp_t          evt_stamp,
   output logic                       trig_out,
   output trace_pkg::drop_count_t     drop_count
);
   import trace_pkg::*;

   window_t   window_d;    // window that produced the current hits
   stamp_t    stamp_d;
   rule_idx_t win_rule;
   logic      any_hit;
   credit_t   credits;
   logic      issue;
   logic      drop;

   // hits lag the window by one edge
   always_ff @(posedge bus.trace_clk) begin
      if (bus.window_valid) begin
         window_d <= bus.window;
         stamp_d  <= bus.stamp;
      end
   end

   // lowest numbered rule wins
   always_comb begin
      win_rule = '0;
      for (int i = NUM_RULES - 1; i >= 0; i--) begin
         if (hits[i])
            win_rule = rule_idx_t'(i);
      end
   end

   assign any_hit = |hits;
   assign issue   = any_hit && (credits != '0);
   assign drop    = any_hit && (credits == '0);   // late credit cannot help

   always_ff @(posedge bus.trace_clk) begin
      if (bus.reset) begin
         credits <= credit_t'(EVT_CREDITS);
      end else begin
         credits <= credits - credit_t'(issue) + credit_t'(evt_credit);
      end
   end

   always_ff @(posedge bus.trace_clk) begin
      if (bus.reset) begin
         evt_valid  <= 1'b0;
         trig_out   <= 1'b0;
         drop_count <= '0;
      end else begin
         evt_valid <= issue;
         trig_out  <= |trig_hits;        // independent of credits
         if (drop && drop_count != '1)
            drop_count <= drop_count + 1'b1;
      end
   end

   // event payload
   always_ff @(posedge bus.trace_clk) begin
      if (issue) begin
         evt_rule   <= win_rule;
         evt_window <= window_d;
         evt_stamp  <= stamp_d;
      end
   end

endmodule

`default_nettype wire

// ==== trace_match_top.sv ====
/*
  Top level of the trace matcher: trace shifter, eight pattern rules
  and the match reporter joined by the trace bus.
*/
`timescale 1ns/100ps
`default_nettype none

module trace_match_top (
   input  logic                   trace_clk,
   input  logic                   reset,
   input  logic                   trace_en,
   input  trace_pkg::nibble_t     trace_data,
   input  logic                   cfg_wr,
   input  trace_pkg::rule_idx_t   cfg_rule,
   input  trace_pkg::cfg_field_e  cfg_field,
   input  trace_pkg::window_t     cfg_data,
   input  logic                   evt_credit,
   output logic                   evt_valid,
   output trace_pkg::rule_idx_t   evt_rule,
   output trace_pkg::window_t     evt_window,
   output trace_pkg::stamp_t      evt_stamp,
   output logic                   trig_out,
   output trace_pkg::drop_count_t drop_count
);
   import trace_pkg::*;

   rule_vec_t hits;
   rule_vec_t trig_hits;

   trace_bus_if u_bus (
      .trace_clk (trace_clk),
      .reset     (reset)
   );

   trace_shifter u_shifter (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .trace_en   (trace_en),
      .trace_data (trace_data),
      .cfg_wr     (cfg_wr),
      .cfg_rule   (cfg_rule),
      .cfg_field  (cfg_field),
      .cfg_data   (cfg_data),
      .bus        (u_bus.src)
   );

   for (genvar g = 0; g < NUM_RULES; g++) begin : g_rule
      pattern_rule #(
         .RULE_ID (rule_idx_t'(g))
      ) u_rule (
         .bus      (u_bus.rule),
         .hit      (hits[g]),
         .trig_hit (trig_hits[g])
      );
   end

   match_reporter u_reporter (
      .bus        (u_bus.mon),
      .hits       (hits),
      .trig_hits  (trig_hits),
      .evt_credit (evt_credit),
      .evt_valid  (evt_valid),
      .evt_rule   (evt_rule),
      .evt_window (evt_window),
      .evt_stamp  (evt_stamp),
      .trig_out   (trig_out),
      .drop_count (drop_count)
   );

endmodule

`default_nettype wire

// ==== tb_trace_match.sv ====
/*
  Testbench for the trace matcher with clock and reset, config writes,
  window and timestamp model with reference match function,
  credit consumer, event and trigger checker, timeout and summary.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_trace_match;
   import trace_pkg::*;

   localparam int RAND_LEN    = 600;                  // random stream nibbles
   localparam int STIM_CYCLES = 330 + RAND_LEN;       // directed part is about 330
   localparam int TIMEOUT     = 2 * STIM_CYCLES + 100;

   typedef struct packed {
      logic      hit;
      rule_idx_t rule;
      logic      trig;
      window_t   window;
      stamp_t    stamp;
   } match_t;

   typedef struct packed {
      rule_idx_t rule;
      window_t   window;
      stamp_t    stamp;
      int        due;                                 // edge that shows it
   } exp_evt_t;

   logic        trace_clk = 1'b0;
   logic        reset = 1'b1;
   logic        trace_en = 1'b0;
   nibble_t     trace_data = '0;
   logic        cfg_wr = 1'b0;
   rule_idx_t   cfg_rule = '0;
   cfg_field_e  cfg_field = cfg_pattern;
   window_t     cfg_data = '0;
   logic        evt_credit = 1'b0;
   logic        evt_valid;
   rule_idx_t   evt_rule;
   window_t     evt_window;
   stamp_t      evt_stamp;
   logic        trig_out;
   drop_count_t drop_count;

   window_t     sh_pat [NUM_RULES];                   // shadow rule configs
   window_t     sh_mask [NUM_RULES];
   logic        sh_en [NUM_RULES];
   logic        sh_trig [NUM_RULES];
   window_t     win_m = '0;
   int          fill_m = 0;
   stamp_t      stamp_m = '0;
   match_t      stage = '0;                           // result waiting for its hit edge
   int          cred_m = EVT_CREDITS;
   logic        pend1 = 1'b0;                         // issue decided last step
   logic        pend2 = 1'b0;
   int          owed = 0;                             // credits the consumer holds back
   logic        auto_credit = 1'b1;
   drop_count_t drops_m = '0;
   logic        cfg_pend = 1'b0;
   rule_idx_t   wr_rule = '0;
   cfg_field_e  wr_field = cfg_pattern;
   window_t     wr_data = '0;
   exp_evt_t    evt_q [$];
   int          trig_q [$];
   int          edge_cnt = 0;
   int          val_errs = 0;
   int          other_errs = 0;
   string       test_name = "reset";
   int unsigned seed_val;

   trace_match_top dut0 (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .trace_en   (trace_en),
      .trace_data (trace_data),
      .cfg_wr     (cfg_wr),
      .cfg_rule   (cfg_rule),
      .cfg_field  (cfg_field),
      .cfg_data   (cfg_data),
      .evt_credit (evt_credit),
      .evt_valid  (evt_valid),
      .evt_rule   (evt_rule),
      .evt_window (evt_window),
      .evt_stamp  (evt_stamp),
      .trig_out   (trig_out),
      .drop_count (drop_count)
   );

   always #5 trace_clk = ~trace_clk;

   always @(posedge trace_clk) begin
      edge_cnt++;
      if (edge_cnt > TIMEOUT) begin
         $display("timeout: stimulus still running after %0d cycles", edge_cnt);
         $display("summary: %0d wrong values, %0d other errors", val_errs, other_errs + 1);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic check_rule(input rule_idx_t exp, input rule_idx_t act);
      if (act !== exp) begin
         val_errs++;
         $display("FAILED %s: rule expected %0d actual %0d", test_name, exp, act);
      end
   endtask

   task automatic check_window(input window_t exp, input window_t act);
      if (act !== exp) begin
         val_errs++;
         $display("FAILED %s: window expected %h actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_stamp(input stamp_t exp, input stamp_t act);
      if (act !== exp) begin
         val_errs++;
         $display("FAILED %s: stamp expected %0d actual %0d", test_name, exp, act);
      end
   endtask

   task automatic check_drops(input drop_count_t exp, input drop_count_t act);
      if (act !== exp) begin
         val_errs++;
         $display("FAILED %s: drop_count expected %0d actual %0d", test_name, exp, act);
      end
   endtask

   task automatic check_trig(input logic exp, input logic act);
      if (act !== exp) begin
         val_errs++;
         $display("FAILED %s: trig_out expected %b actual %b", test_name, exp, act);
      end
   endtask

   // event and trigger compare on the falling edge
   always @(negedge trace_clk) begin : check_outputs
      exp_evt_t e;
      logic     exp_trig;
      if (!reset) begin
         if (evt_valid !== 1'b0) begin
            if (evt_q.size() == 0 || evt_q[0].due != edge_cnt) begin
               other_errs++;
               $display("%s: event from rule %0d that nobody expected", test_name, evt_rule);
            end else begin
               e = evt_q.pop_front();
               check_rule(e.rule, evt_rule);
               check_window(e.window, evt_window);
               check_stamp(e.stamp, evt_stamp);
            end
         end else if (evt_q.size() != 0 && evt_q[0].due == edge_cnt) begin
            e = evt_q.pop_front();
            other_errs++;
            $display("%s: event for rule %0d never appeared", test_name, e.rule);
         end
         exp_trig = (trig_q.size() != 0 && trig_q[0] == edge_cnt);
         check_trig(exp_trig, trig_out);
         if (exp_trig)
            trig_q.pop_front();
      end
   end

   // lowest enabled matching rule wins
   function automatic match_t ref_match(input window_t w);
      match_t m;
      m = '0;
      for (int i = NUM_RULES - 1; i >= 0; i--) begin
         if (sh_en[i] && ((w ^ sh_pat[i]) & sh_mask[i]) == '0) begin
            m.hit  = 1'b1;
            m.rule = rule_idx_t'(i);
            m.trig = m.trig | sh_trig[i];             // any enabled match may trigger
         end
      end
      return m;
   endfunction

   // drive one cycle of inputs and advance the model to the next edge
   task automatic step(input logic en, input nibble_t nib, input logic force_cred);
      logic     cred;
      logic     issue;
      exp_evt_t ev;
      @(negedge trace_clk);
      owed  = owed + int'(pend2);                     // event now visible to consumer
      pend2 = pend1;
      cred  = force_cred || (auto_credit && owed > 0);
      if (cred)
         owed--;
      trace_en   = en;
      trace_data = nib;
      evt_credit = cred;
      cfg_wr     = cfg_pend;
      cfg_rule   = wr_rule;
      cfg_field  = wr_field;
      cfg_data   = wr_data;
      cfg_pend   = 1'b0;
      cred_m = cred_m - int'(pend1) + int'(cred);     // credits after the coming edge
      issue  = 1'b0;
      if (stage.hit && cred_m != 0) begin
         issue     = 1'b1;
         ev.rule   = stage.rule;
         ev.window = stage.window;
         ev.stamp  = stage.stamp;
         ev.due    = edge_cnt + 2;
         evt_q.push_back(ev);
      end else if (stage.hit && drops_m != '1) begin
         drops_m++;
      end
      if (stage.trig)
         trig_q.push_back(edge_cnt + 2);
      pend1 = issue;
      stage = '0;
      if (en) begin
         win_m = {win_m[WINDOW_BITS-5:0], nib};
         if (fill_m < WINDOW_NIBBLES)
            fill_m++;
         if (fill_m == WINDOW_NIBBLES) begin
            stage        = ref_match(win_m);
            stage.window = win_m;
            stage.stamp  = stamp_m;
         end
      end else begin
         fill_m = 0;
      end
      stamp_m++;
   endtask

   task automatic write_cfg(input rule_idx_t r, input cfg_field_e f, input window_t d);
      cfg_pend = 1'b1;
      wr_rule  = r;
      wr_field = f;
      wr_data  = d;
      case (f)
         cfg_pattern: sh_pat[r] = d;
         cfg_mask:    sh_mask[r] = d;
         default: begin
            sh_en[r]   = d[0];
            sh_trig[r] = d[1];
         end
      endcase
      step(1'b0, '0, 1'b0);
   endtask

   task automatic set_rule(input rule_idx_t r, input window_t pat, input window_t mask,
                           input logic [1:0] en);
      write_cfg(r, cfg_pattern, pat);
      write_cfg(r, cfg_mask, mask);
      write_cfg(r, cfg_enable, window_t'(en));
   endtask

   task automatic disable_all();
      for (int r = 0; r < NUM_RULES; r++)
         write_cfg(rule_idx_t'(r), cfg_enable, '0);
   endtask

   task automatic stream_part(input window_t w, input int hi, input int lo);
      for (int i = hi; i >= lo; i--)
         step(1'b1, w[4*i +: 4], 1'b0);           // oldest nibble first
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, '0, 1'b0);
   endtask

   task automatic random_rules();
      window_t m;
      for (int r = 0; r < NUM_RULES; r++) begin
         m = '0;
         repeat (3) m[$urandom % WINDOW_BITS] = 1'b1;   // sparse so hits occur
         set_rule(rule_idx_t'(r), {$urandom, $urandom}, m, 2'($urandom));
      end
   endtask

   initial begin
      seed_val = $urandom(32'h9688131f);
      for (int r = 0; r < NUM_RULES; r++) begin
         sh_pat[r]  = '0;
         sh_mask[r] = '0;
         sh_en[r]   = 1'b0;
         sh_trig[r] = 1'b0;
      end
      repeat (10) @(posedge trace_clk);
      @(negedge trace_clk);
      reset   = 1'b0;
      stamp_m = 1;                                  // first stepped edge reads stamp 1

      test_name = "single match";
      set_rule(3'd3, 64'h0123_4567_89ab_cdef, '1, 2'b01);
      stream_part(64'h0123_4567_89ab_cdef, 15, 0);
      idle(4);
      write_cfg(3'd3, cfg_enable, 64'd3);
      stream_part(64'h0123_4567_89ab_cdef, 15, 0);
      idle(4);
      check_drops('0, drop_count);

      test_name = "mask and enable";
      write_cfg(3'd3, cfg_enable, '0);
      set_rule(3'd1, 64'hfeed_c0de_1357_9bdf, 64'hffff_0000_ffff_ff0f, 2'b01);
      stream_part(64'hfeed_c0de_1357_9bdf ^ 64'h0000_a5a5_0000_0050, 15, 0);
      idle(4);
      set_rule(3'd6, 64'h5a5a_3c3c_9696_0ff0, '1, 2'b10);
      stream_part(64'h5a5a_3c3c_9696_0ff0, 15, 0);
      idle(4);
      stream_part(64'hfeed_c0de_1357_9bdf ^ 64'h1, 15, 0);
      idle(4);
      disable_all();

      test_name = "priority";
      set_rule(3'd2, 64'h7777_1234_abcd_0001, '1, 2'b01);
      set_rule(3'd5, 64'h7777_1234_abcd_0001, 64'hffff_ffff_0000_0000, 2'b11);
      stream_part(64'h7777_1234_abcd_0001, 15, 0);
      idle(4);
      disable_all();

      test_name = "credits";
      auto_credit = 1'b0;
      set_rule(3'd0, '0, '0, 2'b11);                // every valid window hits and triggers
      stream_part(64'h1111_2222_3333_4444, 15, 0);
      repeat (5) step(1'b1, 4'h9, 1'b0);
      idle(4);
      check_drops(8'd2, drop_count);
      step(1'b0, '0, 1'b1);                         // single credit back
      idle(2);
      stream_part(64'h1111_2222_3333_4444, 15, 0);
      idle(4);
      check_drops(8'd2, drop_count);
      auto_credit = 1'b1;
      write_cfg(3'd0, cfg_enable, '0);
      idle(8);

      test_name = "fill restart";
      set_rule(3'd4, 64'hc001_d00d_4242_8e8e, '1, 2'b01);
      stream_part(64'hc001_d00d_4242_8e8e, 15, 6);
      step(1'b0, '0, 1'b0);                         // gap inside the pattern
      stream_part(64'hc001_d00d_4242_8e8e, 5, 0);
      idle(4);
      stream_part(64'hc001_d00d_4242_8e8e, 15, 0);
      idle(4);
      disable_all();

      test_name = "random stream";
      random_rules();
      repeat (RAND_LEN) step(($urandom % 40) != 0, nibble_t'($urandom), 1'b0);
      idle(6);
      check_drops(drops_m, drop_count);
      check_drops(8'd2, drop_count);                // only the credit test drops
      idle(8);

      if (evt_q.size() != 0 || trig_q.size() != 0) begin
         other_errs++;
         $display("%0d events and %0d triggers were expected but never seen",
                  evt_q.size(), trig_q.size());
      end
      $display("summary: %0d wrong values, %0d other errors", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
trace_pkg.sv
trace_bus_if.sv
trace_shifter.sv
pattern_rule.sv
match_reporter.sv
trace_match_top.sv
tb_trace_match.sv

// ==== Bender.yml ====
package:
  name: trace_match

sources:
  # design, in compile order
  - trace_pkg.sv
  - trace_bus_if.sv
  - trace_shifter.sv
  - pattern_rule.sv
  - match_reporter.sv
  - trace_match_top.sv
  - target: simulation
    files:
      - tb_trace_match.sv
